// File: flist.f
+incdir+include
hw/soc_pkg.sv
hw/axi_xbar.sv
hw/axi_sram.sv
hw/axi_uart_tx.sv
hw/soc_top.sv
tb/soc_props.sv
tb/soc_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = soc_tb
FLIST    = flist.f
RUN_ARGS = +verilator+error+limit+100

SRCS    = $(filter-out +%,$(shell cat $(FLIST)))
HEADERS = $(wildcard include/*.svh)
BIN     = obj_dir/V$(TOP)
LOG     = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HEADERS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb/soc_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "soc_settings.svh"

module soc_tb import soc_pkg::*; ();

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_WAIT_TX
  } op_e;

  typedef struct packed {
    op_e   op;
    addr_t addr;
    data_t data;
    strb_t strb;
    data_t exp_data;  // SRAM reads take theirs from the shadow copy
    resp_t exp_resp;
  } test_t;

  localparam int NUM_TESTS = 18;
  localparam int TIMEOUT   = NUM_TESTS * (10 * `UART_DIV + 20) + 50;

  logic       clock;
  logic       reset;
  axi_req_t   req;
  axi_rsp_t   rsp;
  logic       txd;
  test_t      tests [NUM_TESTS];
  data_t      shadow [`SRAM_WORDS];
  logic [7:0] exp_q [$];  // Bytes written to the UART data register
  logic [7:0] rx_q [$];   // Bytes decoded from txd
  int         seed = 32'h86da92fb;
  int         errors = 0;
  int         frame_errors = 0;
  int         tests_failed = 0;
  int         cycles = 0;

  soc_top dut_i (
    .clock (clock),
    .reset (reset),
    .req   (req),
    .rsp   (rsp),
    .txd   (txd)
  );

  bind soc_top soc_props props_i (
    .clock      (clock),
    .reset      (reset),
    .req        (req),
    .rsp        (rsp),
    .grant      (xbar_i.state),
    .uart_state (uart_i.state),
    .txd        (txd)
  );

  always #50 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  function automatic logic in_sram(addr_t addr);
    return addr >= `SRAM_BASE && addr < `SRAM_BASE + `REGION_SIZE;
  endfunction

  // One single-beat transaction with the response taken after a random delay
  task automatic xfer(input test_t t, output data_t rdata, output resp_t resp);
    logic [31:0] rnd;
    logic        is_rd;
    is_rd        = t.op == OP_READ;
    req.ar_valid = is_rd;
    req.ar_addr  = t.addr;
    req.aw_valid = !is_rd;
    req.aw_addr  = t.addr;
    req.w_valid  = !is_rd;
    req.w_data   = t.data;
    req.w_strb   = t.strb;
    @(negedge clock);
    while (!(is_rd ? rsp.ar_ready : (rsp.aw_ready && rsp.w_ready))) begin
      @(negedge clock);
    end
    @(posedge clock);
    #1;
    req.ar_valid = 1'b0;
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
    while (!(rsp.b_valid || rsp.r_valid)) begin
      @(posedge clock);
      #1;
    end
    resp  = is_rd ? rsp.r_resp : rsp.b_resp;
    rdata = rsp.r_data;
    rnd   = $random(seed);
    repeat (rnd[1:0]) begin
      @(posedge clock);
      #1;
      check_equal(32'(is_rd ? rsp.r_valid : rsp.b_valid), 32'd1, "valid dropped before ready");
      check_equal(32'(is_rd ? rsp.r_resp : rsp.b_resp), 32'(resp), "response code changed");
      if (is_rd) begin
        check_equal(rsp.r_data, rdata, "read data changed before ready");
      end
    end
    req.b_ready = !is_rd;
    req.r_ready = is_rd;
    @(posedge clock);
    #1;
    req.b_ready = 1'b0;
    req.r_ready = 1'b0;
  endtask

  task automatic wait_frames();
    while (rx_q.size() < exp_q.size()) begin
      @(posedge clock);
    end
    repeat (`UART_DIV) @(posedge clock);  // Stop bit runs out
    #1;
    for (int i = 0; i < exp_q.size(); i++) begin
      check_equal(32'(rx_q[i]), 32'(exp_q[i]), "decoded UART byte");
    end
  endtask

  // Finds the start bit, then samples each bit in its middle
  always begin : rx_decode
    logic [7:0] bits;
    logic       bad;
    @(negedge txd);
    repeat (`UART_DIV / 2) @(posedge clock);
    #1;
    bad = txd !== 1'b0;
    for (int i = 0; i < 8; i++) begin
      repeat (`UART_DIV) @(posedge clock);
      #1;
      bits[i] = txd;
    end
    repeat (`UART_DIV) @(posedge clock);
    #1;
    bad = bad || txd !== 1'b1;
    if (bad) begin
      $display("Frame error at %0t ns: start or stop bit had the wrong level", $time);
      frame_errors++;
    end
    rx_q.push_back(bits);
  end

  initial begin
    resp_t resp;
    data_t rdata;
    data_t exp;
    int    prev_errors;
    clock = 1'b0;
    reset = 1'b1;
    req   = '0;
    tests[0]  = '{OP_WRITE, `SRAM_BASE, 32'hdead_beef, 4'hf, 32'h0, `RESP_OKAY};
    tests[1]  = '{OP_WRITE, `SRAM_BASE + 32'h4, 32'h1234_5678, 4'hf, 32'h0, `RESP_OKAY};
    tests[2]  = '{OP_READ, `SRAM_BASE, 32'h0, 4'h0, 32'h0, `RESP_OKAY};
    tests[3]  = '{OP_WRITE, `SRAM_BASE + 32'h4, 32'ha5a5_a5a5, 4'h5, 32'h0, `RESP_OKAY};
    tests[4]  = '{OP_READ, `SRAM_BASE + 32'h4, 32'h0, 4'h0, 32'h0, `RESP_OKAY};
    tests[5]  = '{OP_WRITE, `SRAM_BASE + 32'hffc, 32'h0bad_f00d, 4'hf, 32'h0, `RESP_OKAY};
    tests[6]  = '{OP_READ, `SRAM_BASE + 32'hffc, 32'h0, 4'h0, 32'h0, `RESP_OKAY};
    tests[7]  = '{OP_WRITE, 32'h2000_0000, 32'hcafe_0001, 4'hf, 32'h0, `RESP_DECERR};
    tests[8]  = '{OP_READ, 32'h2000_0000, 32'h0, 4'h0, 32'h0, `RESP_DECERR};
    tests[9]  = '{OP_READ, `SRAM_BASE, 32'h0, 4'h0, 32'h0, `RESP_OKAY};
    tests[10] = '{OP_WRITE, `UART_BASE, 32'h0000_0055, 4'hf, 32'h0, `RESP_OKAY};
    tests[11] = '{OP_READ, `UART_BASE + 32'h4, 32'h0, 4'h0, 32'h1, `RESP_OKAY};
    tests[12] = '{OP_WRITE, `UART_BASE, 32'h0000_00a3, 4'hf, 32'h0, `RESP_OKAY};
    tests[13] = '{OP_WRITE, `UART_BASE, 32'h0000_000f, 4'hf, 32'h0, `RESP_OKAY};
    tests[14] = '{OP_WAIT_TX, 32'h0, 32'h0, 4'h0, 32'h0, `RESP_OKAY};
    tests[15] = '{OP_READ, `UART_BASE + 32'h4, 32'h0, 4'h0, 32'h0, `RESP_OKAY};
    tests[16] = '{OP_READ, `UART_BASE, 32'h0, 4'h0, 32'h0000_000f, `RESP_OKAY};
    tests[17] = '{OP_READ, `SRAM_BASE + `REGION_SIZE, 32'h0, 4'h0, 32'h0, `RESP_DECERR};
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    check_equal(32'({rsp.aw_ready, rsp.w_ready, rsp.b_valid, rsp.ar_ready, rsp.r_valid}),
                32'd0, "handshake outputs after reset");
    check_equal(32'(txd), 32'd1, "txd level after reset");
    tests_failed = (errors != 0) ? 1 : 0;
    $display("test reset: %s", errors == 0 ? "ok" : "error");
    for (int i = 0; i < NUM_TESTS; i++) begin
      prev_errors = errors;
      if (tests[i].op == OP_WAIT_TX) begin
        wait_frames();
      end else begin
        xfer(tests[i], rdata, resp);
        check_equal(32'(resp), 32'(tests[i].exp_resp), "response code");
      end
      if (tests[i].op == OP_READ) begin
        exp = in_sram(tests[i].addr) ? shadow[tests[i].addr[11:2]] : tests[i].exp_data;
        check_equal(rdata, exp, "read data");
      end
      if (tests[i].op == OP_WRITE && in_sram(tests[i].addr)) begin
        for (int b = 0; b < 4; b++) begin
          if (tests[i].strb[b]) begin
            shadow[tests[i].addr[11:2]][8*b +: 8] = tests[i].data[8*b +: 8];
          end
        end
      end
      if (tests[i].op == OP_WRITE && tests[i].addr == `UART_BASE) begin
        // A data write is held off until every earlier frame is out
        check_equal(32'(rx_q.size()), 32'(exp_q.size()), "frames sent before data write");
        exp_q.push_back(tests[i].data[7:0]);
      end
      if (errors != prev_errors) begin
        tests_failed++;
      end
      $display("test %0d: %s %h %s", i, tests[i].op.name(), tests[i].addr,
               errors == prev_errors ? "ok" : "error");
    end
    check_equal(32'(rx_q.size()), 32'(exp_q.size()), "number of decoded frames");
    $display("Done: %0d tests, %0d failed, %0d check errors, %0d frame errors, %0d assert fails",
             NUM_TESTS + 1, tests_failed, errors, frame_errors, dut_i.props_i.fails);
    if (errors == 0 && frame_errors == 0 && dut_i.props_i.fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/soc_props.sv
`timescale 1ns/1ns
`default_nettype none

module soc_props import soc_pkg::*; (
  input logic        clock,
  input logic        reset,
  input axi_req_t    req,
  input axi_rsp_t    rsp,
  input xbar_state_e grant,
  input uart_state_e uart_state,
  input logic        txd
);

  int   fails = 0;
  logic rsp_stalled;

  // Response up at the master port but not yet taken
  assign rsp_stalled = (rsp.b_valid & ~req.b_ready) | (rsp.r_valid & ~req.r_ready);

  grant_held: assert property (@(posedge clock) disable iff (reset)
    rsp_stalled |=> $stable(grant))
    else begin
      $error("crossbar grant changed while a response waited");
      fails++;
    end

  one_response: assert property (@(posedge clock) disable iff (reset)
    !(rsp.b_valid && rsp.r_valid))
    else begin
      $error("b_valid and r_valid high together");
      fails++;
    end

  txd_idle_high: assert property (@(posedge clock) disable iff (reset)
    (uart_state == TX_IDLE) |-> txd)
    else begin
      $error("txd low while the transmitter is idle");
      fails++;
    end

endmodule

`default_nettype wire

// File: hw/soc_top.sv
`timescale 1ns/1ns
`default_nettype none

module soc_top import soc_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  axi_req_t req,
  output axi_rsp_t rsp,
  output logic     txd
);

  axi_req_t sram_req;
  axi_rsp_t sram_rsp;
  axi_req_t uart_req;
  axi_rsp_t uart_rsp;

  axi_xbar xbar_i (
    .clock    (clock),
    .reset    (reset),
    .mst_req  (req),
    .mst_rsp  (rsp),
    .sram_req (sram_req),
    .sram_rsp (sram_rsp),
    .uart_req (uart_req),
    .uart_rsp (uart_rsp)
  );

  axi_sram sram_i (
    .clock (clock),
    .reset (reset),
    .req   (sram_req),
    .rsp   (sram_rsp)
  );

  axi_uart_tx uart_i (
    .clock (clock),
    .reset (reset),
    .req   (uart_req),
    .rsp   (uart_rsp),
    .txd   (txd)
  );

endmodule

`default_nettype wire

// File: hw/axi_uart_tx.sv
`timescale 1ns/1ns
`default_nettype none
`include "soc_settings.svh"

module axi_uart_tx import soc_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  axi_req_t req,
  output axi_rsp_t rsp,
  output logic     txd
);

  localparam int CNT_W = $clog2(`UART_DIV + 1);

  uart_state_e      state;
  logic [CNT_W-1:0] div_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift_q;
  logic [7:0]       data_q;
  logic             bit_end;
  logic             tx_busy;
  logic             pending;
  logic             wr_data;
  logic             wr_en;
  logic             wr_start;
  logic             rd_en;
  logic             b_valid_q;
  logic             r_valid_q;
  data_t            r_data_q;

  assign tx_busy = state != TX_IDLE;
  assign bit_end = div_cnt == CNT_W'(`UART_DIV - 1);
  assign pending = b_valid_q | r_valid_q;
  assign wr_data = ~req.aw_addr[2];  // Offset 0 is the data register

  // Data writes wait for the shifter to drain
  assign wr_en    = req.aw_valid & req.w_valid & ~pending & ~(wr_data & tx_busy);
  assign wr_start = wr_en & wr_data & req.w_strb[0];
  assign rd_en    = req.ar_valid & ~pending & ~(req.aw_valid & req.w_valid);

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= TX_IDLE;
      div_cnt <= '0;
      bit_idx <= '0;
    end else begin
      div_cnt <= (tx_busy && !bit_end) ? div_cnt + 1'b1 : '0;
      case (state)
        TX_IDLE:  if (wr_start) state <= TX_START;
        TX_START: if (bit_end) state <= TX_DATA;
        TX_DATA: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;  // Wraps back to 0 after bit 7
            if (bit_idx == 3'd7) begin
              state <= TX_STOP;
            end
          end
        end
        default:  if (bit_end) state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (wr_start) begin
      shift_q <= req.w_data[7:0];
      data_q  <= req.w_data[7:0];
    end else if (state == TX_DATA && bit_end) begin
      shift_q <= shift_q >> 1;  // LSB first
    end
    if (rd_en) begin
      r_data_q <= req.ar_addr[2] ? data_t'(tx_busy) : data_t'(data_q);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_en) begin
        b_valid_q <= 1'b1;
      end else if (req.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_en) begin
        r_valid_q <= 1'b1;
      end else if (req.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_comb begin
    case (state)
      TX_START: txd = 1'b0;
      TX_DATA:  txd = shift_q[0];
      default:  txd = 1'b1;  // Idle line and stop bit
    endcase
  end

  always_comb begin
    rsp          = '0;
    rsp.aw_ready = wr_en;
    rsp.w_ready  = wr_en;
    rsp.b_valid  = b_valid_q;
    rsp.b_resp   = `RESP_OKAY;
    rsp.ar_ready = rd_en;
    rsp.r_valid  = r_valid_q;
    rsp.r_data   = r_data_q;
    rsp.r_resp   = `RESP_OKAY;
  end

endmodule

`default_nettype wire

// File: hw/axi_sram.sv
`timescale 1ns/1ns
`default_nettype none
`include "soc_settings.svh"

module axi_sram import soc_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  axi_req_t req,
  output axi_rsp_t rsp
);

  localparam int IDX_W = $clog2(`SRAM_WORDS);
  localparam int BYTES = $bits(strb_t);

  data_t            mem [`SRAM_WORDS];
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic             pending;
  logic             wr_en;
  logic             rd_en;
  logic             b_valid_q;
  logic             r_valid_q;
  data_t            r_data_q;

  assign pending = b_valid_q | r_valid_q;

  // AW and W are taken together
  assign wr_en = req.aw_valid & req.w_valid & ~pending;
  assign rd_en = req.ar_valid & ~pending & ~wr_en;

  assign wr_idx = req.aw_addr[IDX_W+1:2];
  assign rd_idx = req.ar_addr[IDX_W+1:2];

  always_ff @(posedge clock) begin
    if (wr_en) begin
      for (int i = 0; i < BYTES; i++) begin
        if (req.w_strb[i]) begin
          mem[wr_idx][8*i +: 8] <= req.w_data[8*i +: 8];
        end
      end
    end
    if (rd_en) begin
      r_data_q <= mem[rd_idx];
    end
  end

  // Responses stay up until the master takes them
  always_ff @(posedge clock) begin
    if (reset) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_en) begin
        b_valid_q <= 1'b1;
      end else if (req.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_en) begin
        r_valid_q <= 1'b1;
      end else if (req.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_comb begin
    rsp          = '0;
    rsp.aw_ready = wr_en;
    rsp.w_ready  = wr_en;
    rsp.b_valid  = b_valid_q;
    rsp.b_resp   = `RESP_OKAY;
    rsp.ar_ready = rd_en;
    rsp.r_valid  = r_valid_q;
    rsp.r_data   = r_data_q;
    rsp.r_resp   = `RESP_OKAY;
  end

endmodule

`default_nettype wire

// File: hw/axi_xbar.sv
`timescale 1ns/1ns
`default_nettype none
`include "soc_settings.svh"

module axi_xbar import soc_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  axi_req_t mst_req,
  output axi_rsp_t mst_rsp,
  output axi_req_t sram_req,
  input  axi_rsp_t sram_rsp,
  output axi_req_t uart_req,
  input  axi_rsp_t uart_rsp
);

  xbar_state_e state;
  xbar_state_e target;
  addr_t       req_addr;
  logic        req_any;
  logic        done;
  axi_rsp_t    derr_rsp;
  logic        derr_b_valid;
  logic        derr_r_valid;
  logic        derr_wr;
  logic        derr_rd;

  function automatic logic in_region(addr_t addr, addr_t base);
    addr_t offset;
    offset = addr - base;  // Wraps below base, so one compare covers both ends
    return offset < `REGION_SIZE;
  endfunction

  assign req_any  = mst_req.ar_valid | mst_req.aw_valid | mst_req.w_valid;
  assign req_addr = mst_req.ar_valid ? mst_req.ar_addr : mst_req.aw_addr;

  always_comb begin
    if (in_region(req_addr, `SRAM_BASE)) begin
      target = XB_SRAM;
    end else if (in_region(req_addr, `UART_BASE)) begin
      target = XB_UART;
    end else begin
      target = XB_DERR;
    end
  end

  // Response handshake of whichever target holds the grant
  assign done = (mst_rsp.b_valid & mst_req.b_ready) | (mst_rsp.r_valid & mst_req.r_ready);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= XB_IDLE;
    end else if (state == XB_IDLE) begin
      if (req_any) begin
        state <= target;
      end
    end else if (done) begin
      state <= XB_IDLE;
    end
  end

  assign sram_req = (state == XB_SRAM) ? mst_req : '0;
  assign uart_req = (state == XB_UART) ? mst_req : '0;

  always_comb begin
    case (state)
      XB_SRAM: mst_rsp = sram_rsp;
      XB_UART: mst_rsp = uart_rsp;
      XB_DERR: mst_rsp = derr_rsp;
      default: mst_rsp = '0;
    endcase
  end

  // Decode-error responder, reads take priority as in the decode
  assign derr_rd = (state == XB_DERR) & ~derr_b_valid & ~derr_r_valid & mst_req.ar_valid;
  assign derr_wr = (state == XB_DERR) & ~derr_b_valid & ~derr_r_valid & ~mst_req.ar_valid
                   & mst_req.aw_valid & mst_req.w_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      derr_b_valid <= 1'b0;
      derr_r_valid <= 1'b0;
    end else begin
      if (derr_wr) begin
        derr_b_valid <= 1'b1;
      end else if (mst_req.b_ready) begin
        derr_b_valid <= 1'b0;
      end
      if (derr_rd) begin
        derr_r_valid <= 1'b1;
      end else if (mst_req.r_ready) begin
        derr_r_valid <= 1'b0;
      end
    end
  end

  always_comb begin
    derr_rsp          = '0;
    derr_rsp.aw_ready = derr_wr;
    derr_rsp.w_ready  = derr_wr;
    derr_rsp.b_valid  = derr_b_valid;
    derr_rsp.b_resp   = `RESP_DECERR;
    derr_rsp.ar_ready = derr_rd;
    derr_rsp.r_valid  = derr_r_valid;
    derr_rsp.r_data   = '0;
    derr_rsp.r_resp   = `RESP_DECERR;
  end

endmodule

`default_nettype wire

// File: hw/soc_pkg.sv
`default_nettype none

package soc_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;

  // Master to slave
  typedef struct packed {
    logic  aw_valid;
    addr_t aw_addr;
    logic  w_valid;
    data_t w_data;
    strb_t w_strb;
    logic  b_ready;
    logic  ar_valid;
    addr_t ar_addr;
    logic  r_ready;
  } axi_req_t;

  // Slave to master
  typedef struct packed {
    logic  aw_ready;
    logic  w_ready;
    logic  b_valid;
    resp_t b_resp;
    logic  ar_ready;
    logic  r_valid;
    data_t r_data;
    resp_t r_resp;
  } axi_rsp_t;

  typedef enum logic [1:0] {
    XB_IDLE,
    XB_SRAM,
    XB_UART,
    XB_DERR
  } xbar_state_e;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } uart_state_e;

endpackage

`default_nettype wire

// File: include/soc_settings.svh
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Address map
`define SRAM_BASE    32'h8000_0000
`define UART_BASE    32'h1000_0000
`define REGION_SIZE  32'd4096

// On-chip SRAM depth in 32-bit words
`define SRAM_WORDS   1024

// Clock cycles per serial bit
`define UART_DIV     4

// Response codes
`define RESP_OKAY    2'd0
`define RESP_DECERR  2'd3

`endif
